//--- source/rpeak_params.svh
// widths assume 12-bit level-3 positions at most 4095 so every limit fits the 15-bit index
`ifndef RPEAK_PARAMS_SVH
`define RPEAK_PARAMS_SVH

// full-rate ecg sample, two's complement
`define RPEAK_SAMPLE_W 16

// decimated wavelet position from the upstream stage
`define RPEAK_POS_W 12

// full-rate sample index inside one frame
`define RPEAK_IDX_W 15

// level-3 decimation, one position covers 8 samples
`define RPEAK_DECIM_SHIFT 3

// most negative sample, start value of every lane maximum
`define RPEAK_PEAK_INIT {1'b1, {(`RPEAK_SAMPLE_W - 1){1'b0}}}

`endif

//--- source/ecg_types_pkg.sv
// data types only; their widths come from the macro header, which must be on the include path
`include "rpeak_params.svh"

package ecg_types_pkg;

	// signed ecg sample as delivered on the taps
	typedef logic signed [`RPEAK_SAMPLE_W-1:0] sample_t;

	// decimated position, level-3 resolution
	typedef logic [`RPEAK_POS_W-1:0] pos_t;

	// full-rate sample index, counted from zero each frame
	typedef logic [`RPEAK_IDX_W-1:0] idx_t;

endpackage

//--- source/rpeak_ctrl_pkg.sv
// control encodings only; both enums are 2 bits and the unused codes are never produced

package rpeak_ctrl_pkg;

	// how the qrs window is searched for this frame
	typedef enum logic [1:0] {
		MODE_NONE,
		MODE_SERIAL,
		MODE_PARALLEL
	} search_mode_e;

	// per-lane progress through the sample stream
	typedef enum logic [1:0] {
		LANE_IDLE,
		LANE_WAIT,
		LANE_SCAN,
		LANE_DONE
	} lane_state_e;

endpackage

//--- source/rpeak_window_decode.sv
// positions are captured once per frame; a new frame needs enable or search_go to drop first
`timescale 1ns/1ps
`include "rpeak_params.svh"

module rpeak_window_decode
	import ecg_types_pkg::*, rpeak_ctrl_pkg::*;
(
	input  logic         clk,
	input  logic         nReset,
	input  logic         enable,
	input  logic         search_go,
	input  pos_t         min_pos,
	input  pos_t         max_pos,
	input  pos_t         min_pos_n,
	input  pos_t         max_pos_n,
	output search_mode_e mode,
	output idx_t         lo_a,
	output idx_t         hi_a,
	output idx_t         lo_b,
	output idx_t         hi_b,
	output logic         lane_run_a,
	output logic         lane_run_b
);

	logic         go;
	logic         active;
	logic         run_a_q;
	logic         run_b_q;
	search_mode_e mode_d;

	// last full-rate sample covered by a decimated position
	function automatic idx_t expand(input pos_t p);
		idx_t wide;
		wide = idx_t'(p) + idx_t'(1);
		return (wide << `RPEAK_DECIM_SHIFT) - idx_t'(1);
	endfunction

	assign go = enable && search_go;

	always_comb
	begin
		if (min_pos < max_pos)
			mode_d = MODE_SERIAL;
		else if ((min_pos > max_pos) && (min_pos_n != '0) && (max_pos_n != '0))
			mode_d = MODE_PARALLEL;
		else
			mode_d = MODE_NONE;
	end

	always_ff @(posedge clk or negedge nReset)
	begin
		if (!nReset)
		begin
			active  <= 1'b0;
			mode    <= MODE_NONE;
			run_a_q <= 1'b0;
			run_b_q <= 1'b0;
			lo_a    <= '0;
			hi_a    <= '0;
			lo_b    <= '0;
			hi_b    <= '0;
		end
		else if (!go)
		begin
			active  <= 1'b0;
			mode    <= MODE_NONE;
			run_a_q <= 1'b0;
			run_b_q <= 1'b0;
			lo_a    <= '0;
			hi_a    <= '0;
			lo_b    <= '0;
			hi_b    <= '0;
		end
		else if (!active)
		begin
			// frame start
			active <= 1'b1;
			mode   <= mode_d;
			case (mode_d)
				MODE_SERIAL:
				begin
					lo_a <= expand(min_pos);
					hi_a <= expand(max_pos);
					lo_b <= '0;
					hi_b <= '0;
				end
				MODE_PARALLEL:
				begin
					// lane a from the secondary minimum, lane b up to the secondary maximum
					lo_a <= expand(min_pos_n);
					hi_a <= expand(max_pos);
					lo_b <= expand(min_pos);
					hi_b <= expand(max_pos_n);
				end
				default:
				begin
					lo_a <= '0;
					hi_a <= '0;
					lo_b <= '0;
					hi_b <= '0;
				end
			endcase
		end
		else
		begin
			run_a_q <= (mode != MODE_NONE);
			run_b_q <= (mode == MODE_PARALLEL);
		end
	end

	// run drops with go so the lanes clear on the following edge
	assign lane_run_a = run_a_q && go;
	assign lane_run_b = run_b_q && go;

endmodule

//--- source/rpeak_lane_search.sv
// one sample per cycle with no back-pressure; an empty window (lo above hi) reports the start value
`timescale 1ns/1ps
`include "rpeak_params.svh"

module rpeak_lane_search
	import ecg_types_pkg::*, rpeak_ctrl_pkg::*;
(
	input  logic    clk,
	input  logic    nReset,
	input  logic    run,
	input  idx_t    lo,
	input  idx_t    hi,
	input  sample_t tap,
	output sample_t peak,
	output idx_t    peak_idx,
	output logic    searching,
	output logic    done
);

	lane_state_e state;
	idx_t        cnt;
	idx_t        cnt_next;
	sample_t     base;
	logic        in_win;
	logic        take;

	assign cnt_next = cnt + idx_t'(1);

	always_comb
	begin
		// first sampling edge compares against the most negative value
		if (state == LANE_IDLE)
			base = `RPEAK_PEAK_INIT;
		else
			base = peak;
		in_win = (cnt >= lo) && (cnt <= hi);
		// strictly greater, so an equal sample later on keeps the earlier index
		take = run && (state != LANE_DONE) && in_win && (tap > base);
	end

	always_ff @(posedge clk or negedge nReset)
	begin
		if (!nReset)
		begin
			state    <= LANE_IDLE;
			cnt      <= '0;
			peak     <= '0;
			peak_idx <= '0;
		end
		else if (!run)
		begin
			state    <= LANE_IDLE;
			cnt      <= '0;
			peak     <= '0;
			peak_idx <= '0;
		end
		else if (state != LANE_DONE)
		begin
			cnt <= cnt_next;
			if (take)
			begin
				peak     <= tap;
				peak_idx <= cnt;
			end
			else if (state == LANE_IDLE)
			begin
				peak     <= `RPEAK_PEAK_INIT;
				peak_idx <= '0;
			end

			if (cnt == hi)
				state <= LANE_DONE;
			else if (cnt_next >= lo)
				state <= LANE_SCAN;
			else
				state <= LANE_WAIT;
		end
	end

	// stall level towards the sample memory
	assign searching = run && (state != LANE_DONE);
	assign done      = run && (state == LANE_DONE);

endmodule

//--- source/rpeak_select.sv
// done levels must hold until the frame ends; outputs clear on the edge after they fall
`timescale 1ns/1ps

module rpeak_select
	import ecg_types_pkg::*, rpeak_ctrl_pkg::*;
(
	input  logic         clk,
	input  logic         nReset,
	input  search_mode_e mode,
	input  logic         done_a,
	input  logic         done_b,
	input  sample_t      peak_a,
	input  sample_t      peak_b,
	input  idx_t         idx_a,
	input  idx_t         idx_b,
	output sample_t      r_peak,
	output idx_t         r_peak_pos,
	output logic         r_peak_found
);

	logic req_done;
	logic pick_a;

	always_comb
	begin
		case (mode)
			MODE_SERIAL:   req_done = done_a;
			MODE_PARALLEL: req_done = done_a && done_b;
			default:       req_done = 1'b0;
		endcase
		// ties go to lane b
		pick_a = (mode == MODE_SERIAL) || (peak_a > peak_b);
	end

	always_ff @(posedge clk or negedge nReset)
	begin
		if (!nReset)
		begin
			r_peak       <= '0;
			r_peak_pos   <= '0;
			r_peak_found <= 1'b0;
		end
		else if (req_done)
		begin
			r_peak_found <= 1'b1;
			if (pick_a)
			begin
				r_peak     <= peak_a;
				r_peak_pos <= idx_a;
			end
			else
			begin
				r_peak     <= peak_b;
				r_peak_pos <= idx_b;
			end
		end
		else
		begin
			r_peak       <= '0;
			r_peak_pos   <= '0;
			r_peak_found <= 1'b0;
		end
	end

endmodule

//--- source/rpeak_detect_top.sv
// search_a and search_b are advisory stall levels; tap_a and tap_b must deliver a sample every cycle
`timescale 1ns/1ps

module rpeak_detect_top
	import ecg_types_pkg::*, rpeak_ctrl_pkg::*;
(
	input  logic    clk,
	input  logic    nReset,
	input  logic    enable,
	input  logic    search_go,
	input  pos_t    min_pos,
	input  pos_t    max_pos,
	input  pos_t    min_pos_n,
	input  pos_t    max_pos_n,
	input  sample_t tap_a,
	input  sample_t tap_b,
	output sample_t r_peak,
	output idx_t    r_peak_pos,
	output logic    r_peak_found,
	output logic    search_a,
	output logic    search_b,
	output logic    serial_mode,
	output logic    parallel_mode
);

	search_mode_e mode;
	idx_t         lo_a;
	idx_t         hi_a;
	idx_t         lo_b;
	idx_t         hi_b;
	logic         run_a;
	logic         run_b;
	sample_t      peak_a;
	sample_t      peak_b;
	idx_t         idx_a;
	idx_t         idx_b;
	logic         done_a;
	logic         done_b;

	rpeak_window_decode decode_i (
		.clk        (clk),
		.nReset     (nReset),
		.enable     (enable),
		.search_go  (search_go),
		.min_pos    (min_pos),
		.max_pos    (max_pos),
		.min_pos_n  (min_pos_n),
		.max_pos_n  (max_pos_n),
		.mode       (mode),
		.lo_a       (lo_a),
		.hi_a       (hi_a),
		.lo_b       (lo_b),
		.hi_b       (hi_b),
		.lane_run_a (run_a),
		.lane_run_b (run_b)
	);

	rpeak_lane_search lane_a_i (
		.clk       (clk),
		.nReset    (nReset),
		.run       (run_a),
		.lo        (lo_a),
		.hi        (hi_a),
		.tap       (tap_a),
		.peak      (peak_a),
		.peak_idx  (idx_a),
		.searching (search_a),
		.done      (done_a)
	);

	// second lane only runs in parallel mode
	rpeak_lane_search lane_b_i (
		.clk       (clk),
		.nReset    (nReset),
		.run       (run_b),
		.lo        (lo_b),
		.hi        (hi_b),
		.tap       (tap_b),
		.peak      (peak_b),
		.peak_idx  (idx_b),
		.searching (search_b),
		.done      (done_b)
	);

	rpeak_select select_i (
		.clk          (clk),
		.nReset       (nReset),
		.mode         (mode),
		.done_a       (done_a),
		.done_b       (done_b),
		.peak_a       (peak_a),
		.peak_b       (peak_b),
		.idx_a        (idx_a),
		.idx_b        (idx_b),
		.r_peak       (r_peak),
		.r_peak_pos   (r_peak_pos),
		.r_peak_found (r_peak_found)
	);

	assign serial_mode   = (mode == MODE_SERIAL);
	assign parallel_mode = (mode == MODE_PARALLEL);

endmodule

//--- verification/rpeak_properties.sv
// sampled on the rising clock; the reset check expects reset to be released between clock edges
`timescale 1ns/1ps

module rpeak_properties
	import ecg_types_pkg::*;
(
	input logic    clk,
	input logic    nReset,
	input sample_t r_peak,
	input idx_t    r_peak_pos,
	input logic    r_peak_found,
	input logic    search_a,
	input logic    search_b,
	input logic    serial_mode,
	input logic    parallel_mode
);

	// both flags decode from one mode register
	a_mode_exclusive: assert property (@(posedge clk) disable iff (!nReset)
		!(serial_mode && parallel_mode))
		else $error("serial_mode and parallel_mode are both high");

	a_lane_b_quiet: assert property (@(posedge clk) disable iff (!nReset)
		serial_mode |-> !search_b)
		else $error("search_b is high in serial mode");

	// result only after every required lane has finished
	a_found_after_search: assert property (@(posedge clk) disable iff (!nReset)
		((serial_mode && search_a) || (parallel_mode && (search_a || search_b)))
		|-> !r_peak_found)
		else $error("r_peak_found is high while a required lane still searches");

	// first active edge after release must leave every output quiet
	a_reset_clean: assert property (@(posedge clk)
		$rose(nReset) |=> ((r_peak == '0) && (r_peak_pos == '0) && !r_peak_found
		&& !search_a && !search_b && !serial_mode && !parallel_mode))
		else $error("outputs are not cleared in the cycle after reset is released");

endmodule

bind rpeak_detect_top rpeak_properties props_i (
	.clk           (clk),
	.nReset        (nReset),
	.r_peak        (r_peak),
	.r_peak_pos    (r_peak_pos),
	.r_peak_found  (r_peak_found),
	.search_a      (search_a),
	.search_b      (search_b),
	.serial_mode   (serial_mode),
	.parallel_mode (parallel_mode)
);

//--- verification/rpeak_tb.sv
// fixed LFSR seed so every run repeats; tap arrays hold 512 samples, enough for positions up to 60
`timescale 1ns/1ps
`include "rpeak_params.svh"

module rpeak_tb
	import ecg_types_pkg::*, rpeak_ctrl_pkg::*;
;

	typedef logic [8:0] addr_t;

	logic    clk;
	logic    nReset;
	logic    enable;
	logic    search_go;
	pos_t    min_pos;
	pos_t    max_pos;
	pos_t    min_pos_n;
	pos_t    max_pos_n;
	sample_t tap_a;
	sample_t tap_b;
	sample_t r_peak;
	idx_t    r_peak_pos;
	logic    r_peak_found;
	logic    search_a;
	logic    search_b;
	logic    serial_mode;
	logic    parallel_mode;

	logic [31:0] lfsr_state = 32'he8b5;
	sample_t     mem_a [0:511];
	sample_t     mem_b [0:511];

	rpeak_detect_top dut_i (
		.clk           (clk),
		.nReset        (nReset),
		.enable        (enable),
		.search_go     (search_go),
		.min_pos       (min_pos),
		.max_pos       (max_pos),
		.min_pos_n     (min_pos_n),
		.max_pos_n     (max_pos_n),
		.tap_a         (tap_a),
		.tap_b         (tap_b),
		.r_peak        (r_peak),
		.r_peak_pos    (r_peak_pos),
		.r_peak_found  (r_peak_found),
		.search_a      (search_a),
		.search_b      (search_b),
		.serial_mode   (serial_mode),
		.parallel_mode (parallel_mode)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic pos_t rand_pos(input int lo, input int hi);
		return pos_t'(lo + int'(rand_bits(8)) % (hi - lo + 1));
	endfunction

	function automatic addr_t mem_addr(input int k);
		return addr_t'(k);
	endfunction

	// last full-rate sample of a decimated position
	function automatic idx_t window_limit(input pos_t p);
		return idx_t'((int'(p) + 1) * (2 ** `RPEAK_DECIM_SHIFT) - 1);
	endfunction

	function automatic search_mode_e classify_mode(input pos_t mn, input pos_t mx,
		input pos_t mnn, input pos_t mxn);
		if (mn < mx)
			return MODE_SERIAL;
		if ((mn > mx) && (mnn != '0) && (mxn != '0))
			return MODE_PARALLEL;
		return MODE_NONE;
	endfunction

	task automatic put_sample(input logic lane_b, input int k, input sample_t s);
		if ((k >= 0) && (k < 512))
		begin
			if (lane_b)
				mem_b[mem_addr(k)] = s;
			else
				mem_a[mem_addr(k)] = s;
		end
	endtask

	task automatic fill_taps();
		int k;
		for (k = 0; k < 512; k++)
		begin
			mem_a[mem_addr(k)] = sample_t'(rand_bits(16));
			mem_b[mem_addr(k)] = sample_t'(rand_bits(16));
		end
	endtask

	// first strictly greatest sample inside the window
	task automatic lane_max(input logic lane_b, input idx_t lo, input idx_t hi,
		output sample_t pk, output idx_t at);
		sample_t s;
		int      k;
		pk = `RPEAK_PEAK_INIT;
		at = '0;
		for (k = int'(lo); k <= int'(hi); k++)
		begin
			s = lane_b ? mem_b[mem_addr(k)] : mem_a[mem_addr(k)];
			if (s > pk)
			begin
				pk = s;
				at = idx_t'(k);
			end
		end
	endtask

	// larger samples just outside the window, and a repeat of the maximum at hi
	task automatic plant_edges(input logic lane_b, input idx_t lo, input idx_t hi);
		sample_t pk;
		idx_t    at;
		put_sample(lane_b, int'(lo) - 1, 16'sh7fff);
		put_sample(lane_b, int'(hi) + 1, 16'sh7fff);
		lane_max(lane_b, lo, hi, pk, at);
		if (at != hi)
			put_sample(lane_b, int'(hi), pk);
	endtask

	// lane b maximum made equal to the lane a maximum
	task automatic force_tie(input sample_t level, input idx_t lo, input idx_t hi);
		int k;
		for (k = int'(lo); k <= int'(hi); k++)
		begin
			if (mem_b[mem_addr(k)] > level)
				mem_b[mem_addr(k)] = level;
		end
		put_sample(1'b1, int'(lo), level);
	endtask

	task automatic stop_with_failure();
		$display(">>> FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_sample(input string name, input sample_t got, input sample_t exp);
		if (got !== exp)
		begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_idx(input string name, input idx_t got, input idx_t exp);
		if (got !== exp)
		begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_idle_outputs();
		check_sample("r_peak", r_peak, '0);
		check_idx("r_peak_pos", r_peak_pos, '0);
		check_flag("r_peak_found", r_peak_found, 1'b0);
		check_flag("search_a", search_a, 1'b0);
		check_flag("search_b", search_b, 1'b0);
		check_flag("serial_mode", serial_mode, 1'b0);
		check_flag("parallel_mode", parallel_mode, 1'b0);
	endtask

	task automatic drive_taps(input int k);
		if ((k >= 0) && (k < 512))
		begin
			tap_a = mem_a[mem_addr(k)];
			tap_b = mem_b[mem_addr(k)];
		end
		else
		begin
			tap_a = '0;
			tap_b = '0;
		end
	endtask

	task automatic run_frame(input pos_t mn, input pos_t mx, input pos_t mnn, input pos_t mxn,
		input logic plant, input logic tie, input int drop_at);
		search_mode_e m;
		idx_t         lo_a;
		idx_t         hi_a;
		idx_t         lo_b;
		idx_t         hi_b;
		sample_t      pk_a;
		sample_t      pk_b;
		sample_t      exp_peak;
		idx_t         at_a;
		idx_t         at_b;
		idx_t         exp_pos;
		int           cyc;
		int           limit;
		logic         found_exp;
		logic         finished;
		m = classify_mode(mn, mx, mnn, mxn);
		lo_a = '0;
		hi_a = '0;
		lo_b = '0;
		hi_b = '0;
		if (m == MODE_SERIAL)
		begin
			lo_a = window_limit(mn);
			hi_a = window_limit(mx);
		end
		else if (m == MODE_PARALLEL)
		begin
			lo_a = window_limit(mnn);
			hi_a = window_limit(mx);
			lo_b = window_limit(mn);
			hi_b = window_limit(mxn);
		end
		fill_taps();
		if (plant && (m != MODE_NONE))
			plant_edges(1'b0, lo_a, hi_a);
		if (tie && (m == MODE_PARALLEL))
		begin
			lane_max(1'b0, lo_a, hi_a, pk_a, at_a);
			force_tie(pk_a, lo_b, hi_b);
		end
		if (plant && (m == MODE_PARALLEL))
			plant_edges(1'b1, lo_b, hi_b);
		lane_max(1'b0, lo_a, hi_a, pk_a, at_a);
		lane_max(1'b1, lo_b, hi_b, pk_b, at_b);
		// lane a wins only when strictly greater
		if ((m == MODE_PARALLEL) && !(pk_a > pk_b))
		begin
			exp_peak = pk_b;
			exp_pos  = at_b;
		end
		else
		begin
			exp_peak = pk_a;
			exp_pos  = at_a;
		end
		// found one edge after index hi is sampled, sampling starts two edges after frame start
		limit = 4 + int'(hi_a);
		if ((m == MODE_PARALLEL) && (hi_b > hi_a))
			limit = 4 + int'(hi_b);
		if (m == MODE_NONE)
			limit = 520;

		@(negedge clk);
		min_pos   = mn;
		max_pos   = mx;
		min_pos_n = mnn;
		max_pos_n = mxn;
		search_go = 1'b1;
		cyc       = 0;
		finished  = 1'b0;
		while (!finished)
		begin
			@(negedge clk);
			cyc++;
			found_exp = (m != MODE_NONE) && (cyc >= limit);
			check_flag("r_peak_found", r_peak_found, found_exp);
			check_sample("r_peak", r_peak, found_exp ? exp_peak : sample_t'(0));
			check_idx("r_peak_pos", r_peak_pos, found_exp ? exp_pos : idx_t'(0));
			check_flag("search_a", search_a,
				(m != MODE_NONE) && (cyc >= 2) && (cyc <= 2 + int'(hi_a)));
			check_flag("search_b", search_b,
				(m == MODE_PARALLEL) && (cyc >= 2) && (cyc <= 2 + int'(hi_b)));
			check_flag("serial_mode", serial_mode, m == MODE_SERIAL);
			check_flag("parallel_mode", parallel_mode, m == MODE_PARALLEL);
			if ((cyc == drop_at) || ((cyc >= limit) && ((m == MODE_NONE) || r_peak_found)))
				finished = 1'b1;
			else if (cyc >= 1000)
			begin
				$display("timeout: r_peak_found did not rise within %0d cycles", cyc);
				stop_with_failure();
			end
			drive_taps(cyc - 2);
		end
		search_go = 1'b0;
		@(negedge clk);
		check_idle_outputs();
	endtask

	initial
	begin
		int   i;
		pos_t a;
		pos_t b;
		pos_t c;
		pos_t d;
		logic p;
		nReset    = 1'b0;
		enable    = 1'b0;
		search_go = 1'b0;
		min_pos   = '0;
		max_pos   = '0;
		min_pos_n = '0;
		max_pos_n = '0;
		tap_a     = '0;
		tap_b     = '0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		nReset = 1'b1;
		enable = 1'b1;
		for (i = 0; i < 3; i++)
		begin
			@(negedge clk);
			check_idle_outputs();
		end

		for (i = 0; i < 10; i++)
		begin
			a = rand_pos(1, 59);
			b = rand_pos(int'(a) + 1, 60);
			c = rand_pos(0, 60);
			d = rand_pos(0, 60);
			p = (rand_bits(1) != 32'd0);
			run_frame(a, b, c, d, p, 1'b0, 0);
		end

		// min above max, secondary positions around them
		for (i = 0; i < 10; i++)
		begin
			b = rand_pos(1, 59);
			a = rand_pos(int'(b) + 1, 60);
			c = rand_pos(1, int'(b));
			d = rand_pos(int'(a), 60);
			p = (rand_bits(1) != 32'd0);
			run_frame(a, b, c, d, p, i[0], 0);
		end

		run_frame(12'd20, 12'd20, 12'd5, 12'd30, 1'b1, 1'b0, 0);
		run_frame(12'd40, 12'd10, 12'd0, 12'd50, 1'b1, 1'b0, 0);
		run_frame(12'd40, 12'd10, 12'd5, 12'd0, 1'b1, 1'b0, 0);

		// abort mid-scan, then a full frame must count from zero again
		run_frame(12'd5, 12'd50, 12'd0, 12'd0, 1'b1, 1'b0, 40);
		run_frame(12'd3, 12'd44, 12'd0, 12'd0, 1'b1, 1'b0, 0);
		run_frame(12'd50, 12'd20, 12'd10, 12'd55, 1'b1, 1'b1, 300);
		run_frame(12'd30, 12'd10, 12'd4, 12'd45, 1'b1, 1'b1, 0);

		$display(">>> PASS");
		$finish;
	end

endmodule

//--- files.f
+incdir+source
source/ecg_types_pkg.sv
source/rpeak_ctrl_pkg.sv
source/rpeak_window_decode.sv
source/rpeak_lane_search.sv
source/rpeak_select.sv
source/rpeak_detect_top.sv
verification/rpeak_properties.sv
verification/rpeak_tb.sv

//--- Makefile
# Verilator flow for the R-peak locator, run from the project root

TOP := rpeak_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f files.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f files.f -Mdir obj_dir -o $(TOP)
	-./obj_dir/$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q '>>> FAIL' sim.log; then \
		echo "simulation reported a failure"; \
		exit 1; \
	fi
	@if ! grep -q '>>> PASS' sim.log; then \
		echo "simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
